// ==== Bender.yml ====
package:
  name: divsqrt_multi

dependencies: {}

sources:
  # Shared package first
  - common/divsqrt_pkg.sv
  # Core blocks
  - divsqrt/divsqrt_ctrl_fsm.sv
  - divsqrt/divsqrt_iter_counter.sv
  - divsqrt/divsqrt_datapath.sv
  - hdl/divsqrt_out_reg.sv
  # Top level
  - hdl/divsqrt_multi.sv
  # Simulation only
  - target: test
    files:
      - test/tb_divsqrt_multi.sv

// ==== common/divsqrt_pkg.sv ====
/*
 * Divide / square-root unit shared definitions
 * Operand and tag widths, iteration counts per operation,
 * operation encodings and status flag positions
 */
package divsqrt_pkg;

  // ------------------------------------------------
  // Widths
  // ------------------------------------------------
  // Unsigned integer operands
  localparam int unsigned DATA_W = 16;
  // Root of a DATA_W radicand needs half the bits
  localparam int unsigned ROOT_W = 8;
  // Request tag carried alongside the operation
  localparam int unsigned TAG_W = 4;
  localparam int unsigned OP_W = 2;

  // ------------------------------------------------
  // Operation encoding
  // ------------------------------------------------
  localparam logic [OP_W-1:0] OP_DIV = 2'd0;
  localparam logic [OP_W-1:0] OP_SQRT = 2'd1;
  // Codes 2 and 3 are illegal, they still run as a square root

  // ------------------------------------------------
  // Iteration counts
  // ------------------------------------------------
  // One quotient bit per cycle
  localparam int unsigned DIV_ITERS = 16;
  // Two radicand bits per cycle
  localparam int unsigned SQRT_ITERS = 8;
  // Must hold DIV_ITERS
  localparam int unsigned CNT_W = 5;

  // ------------------------------------------------
  // Status flags
  // ------------------------------------------------
  localparam int unsigned STATUS_W = 2;
  localparam int unsigned STATUS_DZ = 0;
  localparam int unsigned STATUS_NV = 1;

endpackage

// ==== divsqrt/divsqrt_ctrl_fsm.sv ====
/*
 * Divide / square-root control FSM
 * IDLE -> BUSY -> (HOLD) sequence, gates new starts, presents
 * the result to the output stage and cancels on flush
 */
`timescale 1ns/100ps

module divsqrt_ctrl_fsm (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic flush_i,
  // Upstream handshake
  input  logic in_valid_i,
  output logic in_ready_o,
  // Datapath and counter
  output logic start_o,
  input  logic done_i,
  // Output stage handshake
  output logic res_valid_o,
  input  logic res_ready_i,
  output logic busy_o
);

  typedef enum logic [1:0] {IDLE, BUSY, HOLD} state_e;

  state_e state_q, state_d;

  // ------------------------------------------------
  // Next state and handshake outputs
  // ------------------------------------------------
  always_comb begin
    in_ready_o  = 1'b0;
    res_valid_o = 1'b0;
    busy_o      = 1'b0;
    state_d     = state_q;

    unique case (state_q)
      IDLE: begin
        in_ready_o = 1'b1;
        if (in_valid_i) begin
          state_d = BUSY;
        end
      end
      BUSY: begin
        busy_o = 1'b1;
        // Result ready this cycle, offer it downstream
        if (done_i) begin
          res_valid_o = 1'b1;
          if (res_ready_i) begin
            // Handover cycle also takes the next request
            in_ready_o = 1'b1;
            state_d    = in_valid_i ? BUSY : IDLE;
          end else begin
            state_d = HOLD;
          end
        end
      end
      HOLD: begin
        // Datapath keeps its result, keep offering it
        busy_o      = 1'b1;
        res_valid_o = 1'b1;
        if (res_ready_i) begin
          in_ready_o = 1'b1;
          state_d    = in_valid_i ? BUSY : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase

    // Flush wins over everything above
    if (flush_i) begin
      in_ready_o  = 1'b0;
      res_valid_o = 1'b0;
      busy_o      = 1'b0;
      state_d     = IDLE;
    end
  end

  // One-cycle start on every accepted request
  assign start_o = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  // A start only happens in IDLE or in the cycle that hands a result over
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_o |-> !flush_i && ((state_q == IDLE) || (res_valid_o && res_ready_i)));

  // Offered result is not withdrawn before the output stage takes it
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (res_valid_o && !res_ready_i) ##1 !flush_i |-> res_valid_o);

endmodule

// ==== divsqrt/divsqrt_datapath.sv ====
/*
 * Bit-serial divide / square-root datapath
 * Restoring division, one quotient bit per cycle, and
 * digit-by-digit integer square root, two radicand bits per cycle.
 * Results and flags hold until the next start.
 */
`timescale 1ns/100ps

module divsqrt_datapath import divsqrt_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_i,
  input  logic [OP_W-1:0]     op_i,
  input  logic [DATA_W-1:0]   operand_a_i,
  input  logic [DATA_W-1:0]   operand_b_i,
  input  logic [TAG_W-1:0]    tag_i,
  // Steers the iteration counter
  output logic                is_div_o,
  output logic [DATA_W-1:0]   result_o,
  output logic [DATA_W-1:0]   remainder_o,
  output logic [STATUS_W-1:0] status_o,
  output logic [TAG_W-1:0]    tag_o
);

  logic                is_div_q;
  // Dividend / radicand bits still to consume, plus a marker bit
  logic [DATA_W+1:0]   work_q;
  logic [DATA_W-1:0]   divisor_q;
  logic [DATA_W-1:0]   rem_q;
  logic [DATA_W-1:0]   quo_q;
  logic [STATUS_W-1:0] status_q;
  logic [TAG_W-1:0]    tag_q;

  logic                run;
  logic [DATA_W+1:0]   trial_lhs;
  logic [DATA_W+1:0]   trial_rhs;
  logic [DATA_W+2:0]   trial_diff;
  logic                trial_fits;

  // ------------------------------------------------
  // Step control
  // ------------------------------------------------
  // Marker starts in the low bits and walks up with every shift.
  // Once it leaves the low DATA_W bits all steps are done:
  // 16 single shifts for division, 8 double shifts for the root
  assign run = |work_q[DATA_W-1:0];

  // Bypass at start so the counter loads the right length
  assign is_div_o = start_i ? (op_i == OP_DIV) : is_div_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      is_div_q <= 1'b0;
      work_q   <= '0;
    end else if (start_i) begin
      // Unknown op codes fall through to the root
      is_div_q <= (op_i == OP_DIV);
      if (op_i == OP_DIV) begin
        work_q <= {1'b0, operand_a_i, 1'b1};
      end else begin
        work_q <= {operand_a_i, 2'b01};
      end
    end else if (run) begin
      if (is_div_q) begin
        work_q <= {work_q[DATA_W:0], 1'b0};
      end else begin
        work_q <= {work_q[DATA_W-1:0], 2'b00};
      end
    end
  end

  // ------------------------------------------------
  // Shared trial subtraction
  // ------------------------------------------------
  always_comb begin
    if (is_div_q) begin
      // Partial remainder with next dividend bit vs divisor
      trial_lhs = {1'b0, rem_q, work_q[DATA_W]};
      trial_rhs = {2'b00, divisor_q};
    end else begin
      // Remainder with next bit pair vs 4*root + 1
      trial_lhs = {rem_q, work_q[DATA_W+1:DATA_W]};
      trial_rhs = {{(DATA_W-ROOT_W){1'b0}}, quo_q[ROOT_W-1:0], 2'b01};
    end
    trial_diff = {1'b0, trial_lhs} - {1'b0, trial_rhs};
    // No borrow -> subtraction kept, result bit is one
    trial_fits = ~trial_diff[DATA_W+2];
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      divisor_q <= operand_b_i;
      rem_q     <= '0;
      quo_q     <= '0;
      tag_q     <= tag_i;
      // Flags are known before the first step
      status_q[STATUS_DZ] <= (op_i == OP_DIV) && (operand_b_i == '0);
      status_q[STATUS_NV] <= (op_i != OP_DIV) && (op_i != OP_SQRT);
    end else if (run) begin
      // Zero divisor always fits: quotient all ones, remainder = dividend
      rem_q <= trial_fits ? trial_diff[DATA_W-1:0] : trial_lhs[DATA_W-1:0];
      quo_q <= {quo_q[DATA_W-2:0], trial_fits};
    end
  end

  // Root sits in the low ROOT_W bits, upper bits stay zero
  assign result_o    = quo_q;
  assign remainder_o = rem_q;
  assign status_o    = status_q;
  assign tag_o       = tag_q;

endmodule

// ==== divsqrt/divsqrt_iter_counter.sv ====
/*
 * Iteration counter
 * Loads the cycle count of the started operation,
 * counts down and pulses done once at the end
 */
`timescale 1ns/100ps

module divsqrt_iter_counter import divsqrt_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic flush_i,
  input  logic start_i,
  input  logic is_div_i,
  output logic done_o
);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] load_val;

  // Division needs twice the steps of the root
  assign load_val = is_div_i ? CNT_W'(DIV_ITERS) : CNT_W'(SQRT_ITERS);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      done_o <= 1'b0;
    end else if (flush_i) begin
      cnt_q  <= '0;
      done_o <= 1'b0;
    end else begin
      // Last step leaves 1 -> done in the following cycle
      done_o <= (cnt_q == CNT_W'(1));
      if (start_i) begin
        cnt_q <= load_val;
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - CNT_W'(1);
      end
    end
  end

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  // Exactly one done per operation
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_o |=> !done_o);

endmodule

// ==== hdl/divsqrt_multi.sv ====
/*
 * Multi-cycle integer divide / square-root unit
 * Valid/ready request side, control FSM, iteration counter,
 * shift-and-subtract datapath and one registered output stage
 */
`timescale 1ns/100ps

module divsqrt_multi import divsqrt_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,
  // Request side
  input  logic                in_valid_i,
  input  logic [OP_W-1:0]     op_i,
  input  logic [DATA_W-1:0]   operand_a_i,
  input  logic [DATA_W-1:0]   operand_b_i,
  input  logic [TAG_W-1:0]    tag_i,
  output logic                in_ready_o,
  // Result side
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output logic [DATA_W-1:0]   result_o,
  output logic [DATA_W-1:0]   remainder_o,
  output logic [STATUS_W-1:0] status_o,
  output logic [TAG_W-1:0]    tag_o,
  // Work in flight
  output logic                busy_o
);

  logic                start;
  logic                done;
  logic                is_div;
  logic                res_valid;
  logic                res_ready;
  logic                fsm_busy;
  logic [DATA_W-1:0]   dp_result;
  logic [DATA_W-1:0]   dp_remainder;
  logic [STATUS_W-1:0] dp_status;
  logic [TAG_W-1:0]    dp_tag;

  // ------------------------------------------------
  // Control
  // ------------------------------------------------
  divsqrt_ctrl_fsm i_ctrl_fsm (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .flush_i     ( flush_i    ),
    .in_valid_i  ( in_valid_i ),
    .in_ready_o  ( in_ready_o ),
    .start_o     ( start      ),
    .done_i      ( done       ),
    .res_valid_o ( res_valid  ),
    .res_ready_i ( res_ready  ),
    .busy_o      ( fsm_busy   )
  );

  // Iteration length follows the operation kind
  divsqrt_iter_counter i_iter_counter (
    .clk_i    ( clk_i   ),
    .rst_n_i  ( rst_n_i ),
    .flush_i  ( flush_i ),
    .start_i  ( start   ),
    .is_div_i ( is_div  ),
    .done_o   ( done    )
  );

  // ------------------------------------------------
  // Datapath and output stage
  // ------------------------------------------------
  divsqrt_datapath i_datapath (
    .clk_i       ( clk_i        ),
    .rst_n_i     ( rst_n_i      ),
    .start_i     ( start        ),
    .op_i        ( op_i         ),
    .operand_a_i ( operand_a_i  ),
    .operand_b_i ( operand_b_i  ),
    .tag_i       ( tag_i        ),
    .is_div_o    ( is_div       ),
    .result_o    ( dp_result    ),
    .remainder_o ( dp_remainder ),
    .status_o    ( dp_status    ),
    .tag_o       ( dp_tag       )
  );

  divsqrt_out_reg i_out_reg (
    .clk_i       ( clk_i        ),
    .rst_n_i     ( rst_n_i      ),
    .flush_i     ( flush_i      ),
    .valid_i     ( res_valid    ),
    .ready_o     ( res_ready    ),
    .result_i    ( dp_result    ),
    .remainder_i ( dp_remainder ),
    .status_i    ( dp_status    ),
    .tag_i       ( dp_tag       ),
    .valid_o     ( out_valid_o  ),
    .ready_i     ( out_ready_i  ),
    .result_o    ( result_o     ),
    .remainder_o ( remainder_o  ),
    .status_o    ( status_o     ),
    .tag_o       ( tag_o        )
  );

  // Busy while computing, holding, or a result waits downstream
  assign busy_o = fsm_busy | out_valid_o;

endmodule

// ==== hdl/divsqrt_out_reg.sv ====
/*
 * Result output register
 * Single valid/ready stage for result, remainder, flags and tag.
 * Flush drops a held result.
 */
`timescale 1ns/100ps

module divsqrt_out_reg import divsqrt_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,
  // From the FSM / datapath
  input  logic                valid_i,
  output logic                ready_o,
  input  logic [DATA_W-1:0]   result_i,
  input  logic [DATA_W-1:0]   remainder_i,
  input  logic [STATUS_W-1:0] status_i,
  input  logic [TAG_W-1:0]    tag_i,
  // Downstream
  output logic                valid_o,
  input  logic                ready_i,
  output logic [DATA_W-1:0]   result_o,
  output logic [DATA_W-1:0]   remainder_o,
  output logic [STATUS_W-1:0] status_o,
  output logic [TAG_W-1:0]    tag_o
);

  logic load;

  // Take new data when empty or draining this cycle
  assign ready_o = ~valid_o | ready_i;
  assign load    = valid_i & ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else if (flush_i) begin
      valid_o <= 1'b0;
    end else if (ready_o) begin
      valid_o <= valid_i;
    end
  end

  // Data only moves on a transfer
  always_ff @(posedge clk_i) begin
    if (load) begin
      result_o    <= result_i;
      remainder_o <= remainder_i;
      status_o    <= status_i;
      tag_o       <= tag_i;
    end
  end

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  // Stalled result stays put until downstream takes it
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !ready_i && !flush_i) |=>
      valid_o && $stable(result_o) && $stable(remainder_o)
      && $stable(status_o) && $stable(tag_o));

endmodule

// ==== project.f ====
common/divsqrt_pkg.sv
divsqrt/divsqrt_ctrl_fsm.sv
divsqrt/divsqrt_iter_counter.sv
divsqrt/divsqrt_datapath.sv
hdl/divsqrt_out_reg.sv
hdl/divsqrt_multi.sv
test/tb_divsqrt_multi.sv

// ==== test/tb_divsqrt_multi.sv ====
/*
 * Testbench for the multi-cycle divide / square-root unit
 * Directed tests for division, square root, special cases,
 * output back-pressure, flush and reset state, checked
 * against a software reference model
 */
`timescale 1ns/100ps

module tb_divsqrt_multi import divsqrt_pkg::*; ();

  // ------------------------------------------------
  // Test lengths and limits
  // ------------------------------------------------
  localparam int NUM_DIV        = 16;
  localparam int NUM_SQRT       = 16;
  localparam int STALL_CYCLES   = 30;
  localparam int RESULT_TIMEOUT = 4 * DIV_ITERS;
  // Random ops plus the directed ones in the other tests
  localparam int NUM_TESTS      = NUM_DIV + NUM_SQRT + 10;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (DIV_ITERS + 10) + 200;

  logic                clk_i;
  logic                rst_n_i;
  logic                flush_i;
  logic                in_valid_i;
  logic [OP_W-1:0]     op_i;
  logic [DATA_W-1:0]   operand_a_i;
  logic [DATA_W-1:0]   operand_b_i;
  logic [TAG_W-1:0]    tag_i;
  logic                in_ready_o;
  logic                out_valid_o;
  logic                out_ready_i;
  logic [DATA_W-1:0]   result_o;
  logic [DATA_W-1:0]   remainder_o;
  logic [STATUS_W-1:0] status_o;
  logic [TAG_W-1:0]    tag_o;
  logic                busy_o;

  int          errors;
  int          checks;
  logic [15:0] lfsr_state;

  divsqrt_multi DUT (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .flush_i     ( flush_i     ),
    .in_valid_i  ( in_valid_i  ),
    .op_i        ( op_i        ),
    .operand_a_i ( operand_a_i ),
    .operand_b_i ( operand_b_i ),
    .tag_i       ( tag_i       ),
    .in_ready_o  ( in_ready_o  ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .result_o    ( result_o    ),
    .remainder_o ( remainder_o ),
    .status_o    ( status_o    ),
    .tag_o       ( tag_o       ),
    .busy_o      ( busy_o      )
  );

  // 8 ns clock
  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ------------------------------------------------
  // Random source and reference model
  // ------------------------------------------------
  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 16'hB400;
    return n;
  endfunction

  // One LFSR step per bit taken
  task automatic take_random(input int nbits, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      v          = {v[14:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Largest r with r*r <= a
  function automatic int unsigned ref_isqrt(input int unsigned a);
    int unsigned r;
    r = 0;
    while ((r + 1) * (r + 1) <= a) r++;
    return r;
  endfunction

  task automatic compute_expected(input logic [OP_W-1:0] op, input logic [15:0] a,
                                  input logic [15:0] b, output logic [15:0] res,
                                  output logic [15:0] rem, output logic [STATUS_W-1:0] st);
    int unsigned root;
    st = '0;
    if (op == OP_DIV) begin
      if (b == 16'd0) begin
        // Divide by zero: all-ones quotient, dividend as remainder
        res           = 16'hFFFF;
        rem           = a;
        st[STATUS_DZ] = 1'b1;
      end else begin
        res = a / b;
        rem = a % b;
      end
    end else begin
      // Any other code runs as a root
      root = ref_isqrt(a);
      res  = root[15:0];
      rem  = 16'(a - root * root);
      if (op != OP_SQRT) st[STATUS_NV] = 1'b1;
    end
  endtask

  // ------------------------------------------------
  // Handshake helpers
  // ------------------------------------------------
  // Present a request, return right after the acceptance edge
  task automatic send_request(input logic [OP_W-1:0] op, input logic [15:0] a,
                              input logic [15:0] b, input logic [TAG_W-1:0] tag);
    int waited;
    waited = 0;
    @(posedge clk_i);
    in_valid_i  <= 1'b1;
    op_i        <= op;
    operand_a_i <= a;
    operand_b_i <= b;
    tag_i       <= tag;
    @(negedge clk_i);
    while (!in_ready_o && waited < RESULT_TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!in_ready_o) begin
      $display("ERROR at %0t ns: request with tag %0d was never accepted", $time, tag);
      errors++;
    end
    @(posedge clk_i);
    in_valid_i <= 1'b0;
  endtask

  // Count rising edges from the call until the one that raises out_valid_o
  task automatic wait_result(output int lat, output logic got);
    lat = 0;
    got = 1'b0;
    while (!got && lat < RESULT_TIMEOUT) begin
      @(negedge clk_i);
      got = out_valid_o;
      // No result yet, so at least one more rising edge is needed
      if (!got) begin
        lat++;
      end
      checks++;
      if (!busy_o) begin
        $display("FAILED at %0t ns: busy_o low with a request in flight", $time);
        errors++;
      end
    end
    if (!got) begin
      $display("ERROR at %0t ns: no result within %0d cycles", $time, RESULT_TIMEOUT);
      errors++;
    end
  endtask

  task automatic check_output(input string what, input logic [15:0] exp_res,
                              input logic [15:0] exp_rem, input logic [STATUS_W-1:0] exp_st,
                              input logic [TAG_W-1:0] exp_tag);
    checks++;
    if (result_o !== exp_res) begin
      $display("FAILED at %0t ns: %s result %h, expected %h", $time, what, result_o, exp_res);
      errors++;
    end
    if (remainder_o !== exp_rem) begin
      $display("FAILED at %0t ns: %s remainder %h, expected %h", $time, what,
               remainder_o, exp_rem);
      errors++;
    end
    if (status_o !== exp_st) begin
      $display("FAILED at %0t ns: %s status %b, expected %b", $time, what, status_o, exp_st);
      errors++;
    end
    if (tag_o !== exp_tag) begin
      $display("FAILED at %0t ns: %s tag %0d, expected %0d", $time, what, tag_o, exp_tag);
      errors++;
    end
  endtask

  // Full request with latency and value checks
  task automatic run_op(input string what, input logic [OP_W-1:0] op, input logic [15:0] a,
                        input logic [15:0] b, input logic [TAG_W-1:0] tag);
    logic [15:0]         exp_res;
    logic [15:0]         exp_rem;
    logic [STATUS_W-1:0] exp_st;
    int                  exp_lat;
    int                  lat;
    logic                got;
    compute_expected(op, a, b, exp_res, exp_rem, exp_st);
    exp_lat = (op == OP_DIV) ? DIV_ITERS + 1 : SQRT_ITERS + 1;
    send_request(op, a, b, tag);
    wait_result(lat, got);
    if (got) begin
      checks++;
      if (lat != exp_lat) begin
        $display("FAILED at %0t ns: %s latency %0d, expected %0d", $time, what, lat, exp_lat);
        errors++;
      end
      check_output(what, exp_res, exp_rem, exp_st, tag);
    end
  endtask

  // ------------------------------------------------
  // Directed tests
  // ------------------------------------------------
  task automatic test_reset_state();
    @(negedge clk_i);
    checks++;
    if (!in_ready_o || out_valid_o || busy_o) begin
      $display("FAILED at %0t ns: after reset in_ready=%b out_valid=%b busy=%b", $time,
               in_ready_o, out_valid_o, busy_o);
      errors++;
    end
  endtask

  task automatic test_random_div();
    logic [15:0] a;
    logic [15:0] b;
    for (int i = 0; i < NUM_DIV; i++) begin
      take_random(16, a);
      // Short divisors give wide quotients
      take_random((i % 2 == 0) ? 6 : 16, b);
      if (b == 16'd0) b = 16'd1;
      run_op("div", OP_DIV, a, b, TAG_W'(i));
    end
  endtask

  task automatic test_random_sqrt();
    logic [15:0] a;
    run_op("sqrt max", OP_SQRT, 16'hFFFF, 16'd0, 4'hE);
    run_op("sqrt zero", OP_SQRT, 16'd0, 16'd0, 4'hF);
    for (int i = 0; i < NUM_SQRT; i++) begin
      take_random(16, a);
      run_op("sqrt", OP_SQRT, a, 16'd0, TAG_W'(i));
    end
  endtask

  task automatic test_special_cases();
    logic [15:0] a;
    take_random(16, a);
    run_op("div by zero", OP_DIV, a, 16'd0, 4'h3);
    run_op("op code 2", 2'd2, a, 16'd5, 4'h4);
    run_op("op code 3", 2'd3, 16'd1000, 16'd0, 4'h5);
  endtask

  // Result 1 stalls in the output stage, result 2 waits in HOLD
  task automatic test_backpressure();
    logic [15:0]         r1, m1, r2, m2, r3, m3;
    logic [STATUS_W-1:0] s1, s2, s3;
    int                  lat;
    logic                got;
    compute_expected(OP_DIV, 16'd1000, 16'd7, r1, m1, s1);
    compute_expected(OP_SQRT, 16'd50000, 16'd0, r2, m2, s2);
    compute_expected(OP_DIV, 16'hFFFF, 16'd255, r3, m3, s3);
    @(posedge clk_i);
    out_ready_i <= 1'b0;
    send_request(OP_DIV, 16'd1000, 16'd7, 4'h5);
    wait_result(lat, got);
    check_output("stall first", r1, m1, s1, 4'h5);
    send_request(OP_SQRT, 16'd50000, 16'd0, 4'h6);
    repeat (SQRT_ITERS + 4) @(negedge clk_i);
    // Third request waits while the unit holds
    @(posedge clk_i);
    in_valid_i  <= 1'b1;
    op_i        <= OP_DIV;
    operand_a_i <= 16'hFFFF;
    operand_b_i <= 16'd255;
    tag_i       <= 4'h9;
    repeat (STALL_CYCLES) begin
      @(negedge clk_i);
      checks++;
      if (in_ready_o || !out_valid_o || !busy_o) begin
        $display("FAILED at %0t ns: stall in_ready=%b out_valid=%b busy=%b", $time,
                 in_ready_o, out_valid_o, busy_o);
        errors++;
      end
      check_output("stalled", r1, m1, s1, 4'h5);
    end
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    @(negedge clk_i);
    checks++;
    if (!in_ready_o) begin
      $display("FAILED at %0t ns: no back-to-back acceptance on release", $time);
      errors++;
    end
    @(posedge clk_i);
    in_valid_i <= 1'b0;
    wait_result(lat, got);
    check_output("held second", r2, m2, s2, 4'h6);
    // One cycle of the third request already passed above
    wait_result(lat, got);
    checks++;
    if (got && lat != DIV_ITERS) begin
      $display("FAILED at %0t ns: third latency %0d, expected %0d", $time, lat + 1,
               DIV_ITERS + 1);
      errors++;
    end
    check_output("after release", r3, m3, s3, 4'h9);
  endtask

  task automatic test_flush();
    send_request(OP_DIV, 16'd40000, 16'd3, 4'hA);
    repeat (5) @(negedge clk_i);
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    repeat (DIV_ITERS + 4) begin
      @(negedge clk_i);
      checks++;
      if (out_valid_o || !in_ready_o || busy_o) begin
        $display("FAILED at %0t ns: after flush out_valid=%b in_ready=%b busy=%b", $time,
                 out_valid_o, in_ready_o, busy_o);
        errors++;
      end
    end
    run_op("after flush", OP_DIV, 16'd40000, 16'd3, 4'hB);
  endtask

  // ------------------------------------------------
  // Sequence and watchdog
  // ------------------------------------------------
  initial begin
    errors      = 0;
    checks      = 0;
    lfsr_state  = 16'd43690;
    rst_n_i     = 1'b0;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    op_i        = OP_DIV;
    operand_a_i = '0;
    operand_b_i = '0;
    tag_i       = '0;
    out_ready_i = 1'b1;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    test_reset_state();
    test_random_div();
    test_random_sqrt();
    test_special_cases();
    test_backpressure();
    test_flush();
    repeat (4) @(posedge clk_i);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("ERROR: watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule
